/* compile.f */
+incdir+.
serial_bus_pkg.sv
bus_master.sv
bus_arbiter.sv
bus_interconnect.sv
slave_mem.sv
slave_return_mux.sv
serial_bus_top.sv
tb_serial_bus.sv

/* tb_serial_bus.sv */
`include "serial_bus_defs.svh"

module tb_serial_bus;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_RANDOM = 300;
	localparam int CYCLES_PER_TXN = 80;
	localparam int DONE_LIMIT = 200;  // cycles one command may wait or run

	logic                       clk = 1'b0;
	logic                       rst;
	logic                       m1_cmd_valid;
	logic                       m1_cmd_ready;
	logic                       m1_cmd_write;
	serial_bus_pkg::slave_sel_t m1_cmd_slave;
	serial_bus_pkg::addr_t      m1_cmd_addr;
	serial_bus_pkg::data_t      m1_cmd_wdata;
	logic                       m1_done;
	serial_bus_pkg::data_t      m1_rdata;
	logic                       m2_cmd_valid;
	logic                       m2_cmd_ready;
	logic                       m2_cmd_write;
	serial_bus_pkg::slave_sel_t m2_cmd_slave;
	serial_bus_pkg::addr_t      m2_cmd_addr;
	serial_bus_pkg::data_t      m2_cmd_wdata;
	logic                       m2_done;
	serial_bus_pkg::data_t      m2_rdata;

	// expected contents, indexed by the address each slave keeps
	serial_bus_pkg::data_t      model_mem [`SB_NUM_SLAVES][2**`SB_ADDR_LEN];
	serial_bus_pkg::slave_sel_t written_slave [$];
	serial_bus_pkg::addr_t      written_addr [$];
	int                         errors = 0;
	int                         checks = 0;
	int                         cycle = 0;

	serial_bus_top u_serial_bus_top (
		.clk(clk), .rst(rst),
		.m1_cmd_valid(m1_cmd_valid), .m1_cmd_ready(m1_cmd_ready),
		.m1_cmd_write(m1_cmd_write), .m1_cmd_slave(m1_cmd_slave),
		.m1_cmd_addr(m1_cmd_addr), .m1_cmd_wdata(m1_cmd_wdata),
		.m1_done(m1_done), .m1_rdata(m1_rdata),
		.m2_cmd_valid(m2_cmd_valid), .m2_cmd_ready(m2_cmd_ready),
		.m2_cmd_write(m2_cmd_write), .m2_cmd_slave(m2_cmd_slave),
		.m2_cmd_addr(m2_cmd_addr), .m2_cmd_wdata(m2_cmd_wdata),
		.m2_done(m2_done), .m2_rdata(m2_rdata)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	// 2k slaves ignore address bit 11
	function automatic serial_bus_pkg::addr_t kept_addr(input serial_bus_pkg::slave_sel_t slave,
		input serial_bus_pkg::addr_t addr);
		if (slave == 0)
			return addr;
		return addr & ((1 << `SB_SMALL_ADDR_LEN) - 1);
	endfunction

	task automatic check_bit(input string name, input logic got, input logic expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("ERR %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic drive_cmd(input int m, input logic valid, input logic write,
		input serial_bus_pkg::slave_sel_t slave, input serial_bus_pkg::addr_t addr,
		input serial_bus_pkg::data_t wdata);
		if (m == 1) begin
			m1_cmd_valid = valid;
			m1_cmd_write = write;
			m1_cmd_slave = slave;
			m1_cmd_addr = addr;
			m1_cmd_wdata = wdata;
		end else begin
			m2_cmd_valid = valid;
			m2_cmd_write = write;
			m2_cmd_slave = slave;
			m2_cmd_addr = addr;
			m2_cmd_wdata = wdata;
		end
	endtask

	// one command on master m, model update or read check at done
	task automatic run_cmd(input int m, input logic write, input serial_bus_pkg::slave_sel_t slave,
		input serial_bus_pkg::addr_t addr, input serial_bus_pkg::data_t wdata,
		output int done_cycle);
		int waited;
		logic ready;
		logic finished;
		serial_bus_pkg::data_t got;
		serial_bus_pkg::data_t expected;
		serial_bus_pkg::addr_t idx;
		waited = 0;
		ready = 1'b0;
		while (!ready && waited < DONE_LIMIT) begin
			@(negedge clk);
			ready = (m == 1) ? m1_cmd_ready : m2_cmd_ready;
			waited++;
		end
		drive_cmd(m, ready, write, slave, addr, wdata);
		@(negedge clk);  // accepted on the edge just passed
		drive_cmd(m, 1'b0, 1'b0, '0, '0, '0);
		waited = 0;
		finished = 1'b0;
		while (ready && !finished && waited < DONE_LIMIT) begin
			@(negedge clk);
			finished = (m == 1) ? m1_done : m2_done;
			waited++;
		end
		done_cycle = cycle;
		checks++;
		assert (finished) else begin
			errors++;
			$display("master %0d did not accept or finish its command in time", m);
		end
		idx = kept_addr(slave, addr);
		if (finished && write) begin
			model_mem[slave][idx] = wdata;
			written_slave.push_back(slave);
			written_addr.push_back(addr);
		end else if (finished) begin
			got = (m == 1) ? m1_rdata : m2_rdata;
			expected = model_mem[slave][idx];
			checks++;
			assert (got == expected) else begin
				errors++;
				$display("ERR m%0d_rdata: got %h, expected %h (slave %0d, addr %h)",
					m, got, expected, slave, addr);
			end
		end
	endtask

	task automatic random_traffic(input int m, input int count);
		int pick;
		int dc;
		logic write;
		serial_bus_pkg::slave_sel_t slave;
		serial_bus_pkg::addr_t addr;
		serial_bus_pkg::data_t wdata;
		for (int i = 0; i < count; i++) begin
			repeat ($urandom_range(3, 0)) @(negedge clk);  // idle gap
			write = ($urandom_range(1, 0) == 1) || (written_slave.size() == 0);
			wdata = $urandom;
			if (write) begin
				slave = $urandom_range(`SB_NUM_SLAVES - 1, 0);
				addr = $urandom & 12'h81f;  // few addresses, with bit 11 for aliasing
			end else begin
				pick = $urandom_range(written_slave.size() - 1, 0);
				slave = written_slave[pick];
				addr = written_addr[pick];
			end
			run_cmd(m, write, slave, addr, wdata, dc);
		end
	endtask

	initial begin
		int seed;
		int c1;
		int c2;
		rst = 1'b1;
		drive_cmd(1, 1'b0, 1'b0, '0, '0, '0);
		drive_cmd(2, 1'b0, 1'b0, '0, '0, '0);
		seed = $urandom(32'h7eec);
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		repeat (4) begin  // idle bus right after reset
			@(negedge clk);
			check_bit("m1_cmd_ready", m1_cmd_ready, 1'b1);
			check_bit("m2_cmd_ready", m2_cmd_ready, 1'b1);
			check_bit("m1_done", m1_done, 1'b0);
			check_bit("m2_done", m2_done, 1'b0);
		end
		run_cmd(1, 1'b1, 1, 12'h123, 8'h5a, c1);
		run_cmd(1, 1'b0, 1, 12'h123, 8'h00, c1);
		// same address, a different byte in every slave
		for (int s = 0; s < `SB_NUM_SLAVES; s++)
			run_cmd(2, 1'b1, s, 12'h0a7, 8'h30 + s, c1);
		for (int s = 0; s < `SB_NUM_SLAVES; s++)
			run_cmd(2, 1'b0, s, 12'h0a7, 8'h00, c1);
		run_cmd(1, 1'b1, 0, 12'h044, 8'h11, c1);
		run_cmd(1, 1'b1, 0, 12'h844, 8'h22, c1);  // distinct on the 4k slave
		run_cmd(1, 1'b1, 1, 12'h844, 8'h33, c1);
		run_cmd(1, 1'b1, 2, 12'h844, 8'h44, c1);
		run_cmd(2, 1'b0, 0, 12'h044, 8'h00, c1);
		run_cmd(2, 1'b0, 0, 12'h844, 8'h00, c1);
		run_cmd(2, 1'b0, 1, 12'h044, 8'h00, c1);
		run_cmd(2, 1'b0, 2, 12'h044, 8'h00, c1);
		fork
			run_cmd(1, 1'b0, 0, 12'h044, 8'h00, c1);
			run_cmd(2, 1'b0, 2, 12'h044, 8'h00, c2);
		join
		checks++;
		assert (c1 < c2) else begin
			errors++;
			$display("m1 did not finish first after both commands were accepted together");
		end
		fork
			random_traffic(1, NUM_RANDOM / 2);
			random_traffic(2, NUM_RANDOM / 2);
		join
		@(negedge clk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin
		#(NUM_RANDOM * CYCLES_PER_TXN * CLK_PERIOD);
		$display("watchdog expired before all commands completed, errors so far: %0d", errors);
		$display("Finished with errors");
		$finish;
	end

endmodule

/* serial_bus_top.sv */
`include "serial_bus_defs.svh"

module serial_bus_top (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       m1_cmd_valid,
	output logic                       m1_cmd_ready,
	input  logic                       m1_cmd_write,
	input  serial_bus_pkg::slave_sel_t m1_cmd_slave,
	input  serial_bus_pkg::addr_t      m1_cmd_addr,
	input  serial_bus_pkg::data_t      m1_cmd_wdata,
	output logic                       m1_done,
	output serial_bus_pkg::data_t      m1_rdata,
	input  logic                       m2_cmd_valid,
	output logic                       m2_cmd_ready,
	input  logic                       m2_cmd_write,
	input  serial_bus_pkg::slave_sel_t m2_cmd_slave,
	input  serial_bus_pkg::addr_t      m2_cmd_addr,
	input  serial_bus_pkg::data_t      m2_cmd_wdata,
	output logic                       m2_done,
	output serial_bus_pkg::data_t      m2_rdata
);

	// arbitration
	logic m1_request;
	logic m2_request;
	logic m1_grant;
	logic m2_grant;
	logic m1_trans_done;
	logic m2_trans_done;
	logic trans_done;

	// master side serial lines
	serial_bus_pkg::slave_sel_t m1_slave_sel;
	serial_bus_pkg::slave_sel_t m2_slave_sel;
	logic m1_master_valid, m1_write_en, m1_read_en, m1_tx_bit;
	logic m2_master_valid, m2_write_en, m2_read_en, m2_tx_bit;
	logic m1_slave_ready, m1_slave_valid, m1_rx_bit, m1_master_ready;
	logic m2_slave_ready, m2_slave_valid, m2_rx_bit, m2_master_ready;

	// slave side serial lines
	logic [`SB_NUM_SLAVES-1:0] s_master_valid, s_write_en, s_read_en, s_tx_bit;
	logic [`SB_NUM_SLAVES-1:0] s_slave_ready, s_slave_valid, s_rx_bit, s_master_ready;
	logic                       owner;
	serial_bus_pkg::slave_sel_t owner_sel;

	assign trans_done = m1_trans_done | m2_trans_done;

	bus_master u_m1_master (
		.clk(clk), .rst(rst),
		.cmd_valid(m1_cmd_valid), .cmd_ready(m1_cmd_ready), .cmd_write(m1_cmd_write),
		.cmd_slave(m1_cmd_slave), .cmd_addr(m1_cmd_addr), .cmd_wdata(m1_cmd_wdata),
		.done(m1_done), .rdata(m1_rdata),
		.request(m1_request), .grant(m1_grant), .slave_sel(m1_slave_sel),
		.trans_done(m1_trans_done),
		.master_valid(m1_master_valid), .write_en(m1_write_en), .read_en(m1_read_en),
		.tx_bit(m1_tx_bit), .slave_ready(m1_slave_ready), .slave_valid(m1_slave_valid),
		.rx_bit(m1_rx_bit), .master_ready(m1_master_ready)
	);

	bus_master u_m2_master (
		.clk(clk), .rst(rst),
		.cmd_valid(m2_cmd_valid), .cmd_ready(m2_cmd_ready), .cmd_write(m2_cmd_write),
		.cmd_slave(m2_cmd_slave), .cmd_addr(m2_cmd_addr), .cmd_wdata(m2_cmd_wdata),
		.done(m2_done), .rdata(m2_rdata),
		.request(m2_request), .grant(m2_grant), .slave_sel(m2_slave_sel),
		.trans_done(m2_trans_done),
		.master_valid(m2_master_valid), .write_en(m2_write_en), .read_en(m2_read_en),
		.tx_bit(m2_tx_bit), .slave_ready(m2_slave_ready), .slave_valid(m2_slave_valid),
		.rx_bit(m2_rx_bit), .master_ready(m2_master_ready)
	);

	bus_arbiter u_bus_arbiter (
		.clk(clk), .rst(rst),
		.m1_request(m1_request), .m2_request(m2_request), .trans_done(trans_done),
		.m1_grant(m1_grant), .m2_grant(m2_grant),
		.bus_busy()  // observed inside the arbiter only
	);

	bus_interconnect u_bus_interconnect (
		.clk(clk), .rst(rst),
		.m1_grant(m1_grant), .m2_grant(m2_grant),
		.m1_slave_sel(m1_slave_sel), .m2_slave_sel(m2_slave_sel),
		.m1_master_valid(m1_master_valid), .m1_write_en(m1_write_en),
		.m1_read_en(m1_read_en), .m1_tx_bit(m1_tx_bit),
		.m2_master_valid(m2_master_valid), .m2_write_en(m2_write_en),
		.m2_read_en(m2_read_en), .m2_tx_bit(m2_tx_bit),
		.s_master_valid(s_master_valid), .s_write_en(s_write_en),
		.s_read_en(s_read_en), .s_tx_bit(s_tx_bit),
		.owner(owner), .owner_sel(owner_sel)
	);

	for (genvar i = 0; i < `SB_NUM_SLAVES; i++) begin : g_slave
		// slave 0 is the 4k memory, the rest are 2k
		slave_mem #(
			.MEM_ADDR_LEN(i == 0 ? `SB_ADDR_LEN : `SB_SMALL_ADDR_LEN)
		) u_slave_mem (
			.clk(clk), .rst(rst),
			.master_valid(s_master_valid[i]), .write_en(s_write_en[i]),
			.read_en(s_read_en[i]), .tx_bit(s_tx_bit[i]),
			.slave_ready(s_slave_ready[i]), .slave_valid(s_slave_valid[i]),
			.rx_bit(s_rx_bit[i]), .master_ready(s_master_ready[i])
		);
	end

	slave_return_mux u_slave_return_mux (
		.owner(owner), .owner_sel(owner_sel),
		.s_slave_ready(s_slave_ready), .s_slave_valid(s_slave_valid), .s_rx_bit(s_rx_bit),
		.m1_slave_ready(m1_slave_ready), .m1_slave_valid(m1_slave_valid),
		.m1_rx_bit(m1_rx_bit),
		.m2_slave_ready(m2_slave_ready), .m2_slave_valid(m2_slave_valid),
		.m2_rx_bit(m2_rx_bit),
		.m1_master_ready(m1_master_ready), .m2_master_ready(m2_master_ready),
		.s_master_ready(s_master_ready)
	);

endmodule

/* slave_return_mux.sv */
`include "serial_bus_defs.svh"

module slave_return_mux (
	input  logic                       owner,
	input  serial_bus_pkg::slave_sel_t owner_sel,
	input  logic [`SB_NUM_SLAVES-1:0]  s_slave_ready,
	input  logic [`SB_NUM_SLAVES-1:0]  s_slave_valid,
	input  logic [`SB_NUM_SLAVES-1:0]  s_rx_bit,
	output logic                       m1_slave_ready,
	output logic                       m1_slave_valid,
	output logic                       m1_rx_bit,
	output logic                       m2_slave_ready,
	output logic                       m2_slave_valid,
	output logic                       m2_rx_bit,
	input  logic                       m1_master_ready,
	input  logic                       m2_master_ready,
	output logic [`SB_NUM_SLAVES-1:0]  s_master_ready
);

	logic sel_slave_ready;
	logic sel_slave_valid;
	logic sel_rx_bit;
	logic own_master_ready;

	assign own_master_ready = owner ? m2_master_ready : m1_master_ready;

	always_comb begin
		sel_slave_ready = 1'b0;
		sel_slave_valid = 1'b0;
		sel_rx_bit = 1'b0;
		for (int i = 0; i < `SB_NUM_SLAVES; i++) begin
			if (owner_sel == i) begin
				sel_slave_ready = s_slave_ready[i];
				sel_slave_valid = s_slave_valid[i];
				sel_rx_bit = s_rx_bit[i];
			end
			s_master_ready[i] = (owner_sel == i) & own_master_ready;
		end
	end

	// non-owner sees an idle bus
	assign m1_slave_ready = ~owner & sel_slave_ready;
	assign m1_slave_valid = ~owner & sel_slave_valid;
	assign m1_rx_bit = ~owner & sel_rx_bit;
	assign m2_slave_ready = owner & sel_slave_ready;
	assign m2_slave_valid = owner & sel_slave_valid;
	assign m2_rx_bit = owner & sel_rx_bit;

endmodule

/* slave_mem.sv */
`include "serial_bus_defs.svh"

module slave_mem #(
	parameter int MEM_ADDR_LEN = `SB_ADDR_LEN
) (
	input  logic clk,
	input  logic rst,
	input  logic master_valid,
	input  logic write_en,
	input  logic read_en,
	input  logic tx_bit,
	output logic slave_ready,
	output logic slave_valid,
	output logic rx_bit,
	input  logic master_ready
);

	localparam serial_bus_pkg::bit_cnt_t ADDR_LAST = `SB_ADDR_LEN - 1;
	localparam serial_bus_pkg::bit_cnt_t DATA_LAST = `SB_DATA_LEN - 1;

	serial_bus_pkg::slave_state_t state;
	serial_bus_pkg::bit_cnt_t     cnt;
	serial_bus_pkg::addr_t        addr_sr;  // full bus address, low part decoded
	serial_bus_pkg::data_t        data_sr;
	serial_bus_pkg::data_t        tx_sr;
	serial_bus_pkg::data_t        mem [2**MEM_ADDR_LEN];
	logic [MEM_ADDR_LEN-1:0]      mem_addr;
	logic                         is_write;
	logic                         in_fire;
	logic                         out_fire;
	logic                         start_beat;

	assign in_fire = master_valid & slave_ready;
	assign out_fire = slave_valid & master_ready;
	assign start_beat = in_fire & (write_en | read_en) & (state == serial_bus_pkg::S_IDLE);
	assign mem_addr = addr_sr[MEM_ADDR_LEN-1:0];  // 2k slaves drop bit 11

	assign slave_ready = (state == serial_bus_pkg::S_IDLE) |
		(state == serial_bus_pkg::S_ADDR) | (state == serial_bus_pkg::S_WDATA);
	assign slave_valid = (state == serial_bus_pkg::S_RDATA);
	assign rx_bit = tx_sr[`SB_DATA_LEN-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= serial_bus_pkg::S_IDLE;
			cnt <= '0;
		end else begin
			case (state)
				serial_bus_pkg::S_IDLE: if (start_beat) state <= serial_bus_pkg::S_ADDR;
				serial_bus_pkg::S_ADDR: begin
					if (in_fire) begin
						if (cnt == ADDR_LAST) begin
							cnt <= '0;
							state <= is_write ? serial_bus_pkg::S_WDATA :
								serial_bus_pkg::S_MEM;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				serial_bus_pkg::S_WDATA: begin
					if (in_fire) begin
						if (cnt == DATA_LAST) begin
							cnt <= '0;
							state <= serial_bus_pkg::S_MEM;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				serial_bus_pkg::S_MEM: begin
					state <= is_write ? serial_bus_pkg::S_IDLE : serial_bus_pkg::S_RDATA;
				end
				serial_bus_pkg::S_RDATA: begin
					if (out_fire) begin  // hold bit while master is not ready
						if (cnt == DATA_LAST) begin
							cnt <= '0;
							state <= serial_bus_pkg::S_IDLE;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				default: state <= serial_bus_pkg::S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start_beat)
			is_write <= write_en;
		if (in_fire && state == serial_bus_pkg::S_ADDR)
			addr_sr <= {addr_sr[`SB_ADDR_LEN-2:0], tx_bit};
		if (in_fire && state == serial_bus_pkg::S_WDATA)
			data_sr <= {data_sr[`SB_DATA_LEN-2:0], tx_bit};
		if (state == serial_bus_pkg::S_MEM && !is_write)
			tx_sr <= mem[mem_addr];  // sync read, shifted out next
		else if (out_fire)
			tx_sr <= {tx_sr[`SB_DATA_LEN-2:0], 1'b0};
	end

	always_ff @(posedge clk) begin
		if (state == serial_bus_pkg::S_MEM && is_write)
			mem[mem_addr] <= data_sr;
	end

endmodule

/* bus_interconnect.sv */
`include "serial_bus_defs.svh"

module bus_interconnect (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       m1_grant,
	input  logic                       m2_grant,
	input  serial_bus_pkg::slave_sel_t m1_slave_sel,
	input  serial_bus_pkg::slave_sel_t m2_slave_sel,
	input  logic                       m1_master_valid,
	input  logic                       m1_write_en,
	input  logic                       m1_read_en,
	input  logic                       m1_tx_bit,
	input  logic                       m2_master_valid,
	input  logic                       m2_write_en,
	input  logic                       m2_read_en,
	input  logic                       m2_tx_bit,
	output logic [`SB_NUM_SLAVES-1:0]  s_master_valid,
	output logic [`SB_NUM_SLAVES-1:0]  s_write_en,
	output logic [`SB_NUM_SLAVES-1:0]  s_read_en,
	output logic [`SB_NUM_SLAVES-1:0]  s_tx_bit,
	output logic                       owner,     // 0 for m1, 1 for m2
	output serial_bus_pkg::slave_sel_t owner_sel
);

	logic m1_grant_q;
	logic m2_grant_q;
	logic own_master_valid;
	logic own_write_en;
	logic own_read_en;
	logic own_tx_bit;

	always_ff @(posedge clk) begin
		if (rst) begin
			m1_grant_q <= 1'b0;
			m2_grant_q <= 1'b0;
			owner <= 1'b0;
			owner_sel <= '0;
		end else begin
			m1_grant_q <= m1_grant;
			m2_grant_q <= m2_grant;
			if (m1_grant && !m1_grant_q) begin  // grant edge
				owner <= 1'b0;
				owner_sel <= m1_slave_sel;
			end else if (m2_grant && !m2_grant_q) begin
				owner <= 1'b1;
				owner_sel <= m2_slave_sel;
			end
		end
	end

	assign own_master_valid = owner ? m2_master_valid : m1_master_valid;
	assign own_write_en = owner ? m2_write_en : m1_write_en;
	assign own_read_en = owner ? m2_read_en : m1_read_en;
	assign own_tx_bit = owner ? m2_tx_bit : m1_tx_bit;

	always_comb begin
		for (int i = 0; i < `SB_NUM_SLAVES; i++) begin
			s_master_valid[i] = (owner_sel == i) & own_master_valid;  // others see zeros
			s_write_en[i] = (owner_sel == i) & own_write_en;
			s_read_en[i] = (owner_sel == i) & own_read_en;
			s_tx_bit[i] = (owner_sel == i) & own_tx_bit;
		end
	end

	a_sel_in_range: assert property (@(posedge clk) disable iff (rst)
		owner_sel < `SB_NUM_SLAVES);

endmodule

/* bus_arbiter.sv */
`include "serial_bus_defs.svh"

module bus_arbiter (
	input  logic clk,
	input  logic rst,
	input  logic m1_request,
	input  logic m2_request,
	input  logic trans_done,
	output logic m1_grant,
	output logic m2_grant,
	output logic bus_busy
);

	assign bus_busy = m1_grant | m2_grant;

	always_ff @(posedge clk) begin
		if (rst) begin
			m1_grant <= 1'b0;
			m2_grant <= 1'b0;
		end else if (bus_busy) begin
			if (trans_done) begin  // owner finished, drop in next cycle
				m1_grant <= 1'b0;
				m2_grant <= 1'b0;
			end
		end else if (m1_request) begin
			m1_grant <= 1'b1;  // m1 has priority
		end else if (m2_request) begin
			m2_grant <= 1'b1;
		end
	end

	// only one master may own the serial lines
	a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
		!(m1_grant && m2_grant));

endmodule

/* bus_master.sv */
`include "serial_bus_defs.svh"

module bus_master (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       cmd_valid,
	output logic                       cmd_ready,
	input  logic                       cmd_write,
	input  serial_bus_pkg::slave_sel_t cmd_slave,
	input  serial_bus_pkg::addr_t      cmd_addr,
	input  serial_bus_pkg::data_t      cmd_wdata,
	output logic                       done,
	output serial_bus_pkg::data_t      rdata,
	output logic                       request,
	input  logic                       grant,
	output serial_bus_pkg::slave_sel_t slave_sel,
	output logic                       trans_done,
	output logic                       master_valid,
	output logic                       write_en,
	output logic                       read_en,
	output logic                       tx_bit,
	input  logic                       slave_ready,
	input  logic                       slave_valid,
	input  logic                       rx_bit,
	output logic                       master_ready
);

	localparam serial_bus_pkg::bit_cnt_t ADDR_LAST = `SB_ADDR_LEN - 1;
	localparam serial_bus_pkg::bit_cnt_t DATA_LAST = `SB_DATA_LEN - 1;

	serial_bus_pkg::master_state_t state;
	serial_bus_pkg::bit_cnt_t      cnt;
	serial_bus_pkg::addr_t         addr_sr;  // msb goes out first
	serial_bus_pkg::data_t         wdata_sr;
	logic [`SB_DATA_LEN-2:0]       rx_sr;    // first seven read bits
	logic                          is_write;
	logic                          accept;
	logic                          tx_fire;
	logic                          rx_fire;

	assign accept = cmd_valid & cmd_ready;
	assign tx_fire = master_valid & slave_ready;
	assign rx_fire = slave_valid & master_ready;

	assign cmd_ready = (state == serial_bus_pkg::M_IDLE);
	assign request = (state == serial_bus_pkg::M_REQUEST);
	assign master_valid = (state == serial_bus_pkg::M_START) |
		(state == serial_bus_pkg::M_ADDR) | (state == serial_bus_pkg::M_WDATA);
	assign write_en = (state == serial_bus_pkg::M_START) & is_write;  // start beat only
	assign read_en = (state == serial_bus_pkg::M_START) & ~is_write;
	assign tx_bit = (state == serial_bus_pkg::M_WDATA) ? wdata_sr[`SB_DATA_LEN-1] :
		addr_sr[`SB_ADDR_LEN-1];
	assign master_ready = (state == serial_bus_pkg::M_RDATA);  // never stalls the slave
	assign done = (state == serial_bus_pkg::M_DONE);
	assign trans_done = done;  // releases the arbiter

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= serial_bus_pkg::M_IDLE;
			cnt <= '0;
		end else begin
			case (state)
				serial_bus_pkg::M_IDLE: if (accept) state <= serial_bus_pkg::M_REQUEST;
				serial_bus_pkg::M_REQUEST: if (grant) state <= serial_bus_pkg::M_START;
				serial_bus_pkg::M_START: if (tx_fire) state <= serial_bus_pkg::M_ADDR;
				serial_bus_pkg::M_ADDR: begin
					if (tx_fire) begin
						if (cnt == ADDR_LAST) begin
							cnt <= '0;
							state <= is_write ? serial_bus_pkg::M_WDATA :
								serial_bus_pkg::M_RDATA;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				serial_bus_pkg::M_WDATA, serial_bus_pkg::M_RDATA: begin
					if (tx_fire || rx_fire) begin
						if (cnt == DATA_LAST) begin
							cnt <= '0;
							state <= serial_bus_pkg::M_DONE;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				default: state <= serial_bus_pkg::M_IDLE;  // done lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			is_write <= cmd_write;
			slave_sel <= cmd_slave;
			addr_sr <= cmd_addr;
			wdata_sr <= cmd_wdata;
		end
		if (tx_fire && state == serial_bus_pkg::M_ADDR)
			addr_sr <= {addr_sr[`SB_ADDR_LEN-2:0], 1'b0};
		if (tx_fire && state == serial_bus_pkg::M_WDATA)
			wdata_sr <= {wdata_sr[`SB_DATA_LEN-2:0], 1'b0};
		if (rx_fire) begin
			rx_sr <= {rx_sr[`SB_DATA_LEN-3:0], rx_bit};
			if (cnt == DATA_LAST)
				rdata <= {rx_sr, rx_bit};  // held until the next read ends
		end
	end

	// the interconnect routes only the owner, so driving without a grant corrupts the bus
	a_valid_needs_grant: assert property (@(posedge clk) disable iff (rst)
		master_valid |-> grant);

endmodule

/* serial_bus_pkg.sv */
package serial_bus_pkg;

	typedef logic [11:0] addr_t;    // bus address
	typedef logic [7:0] data_t;     // one byte
	typedef logic [1:0] slave_sel_t;
	typedef logic [3:0] bit_cnt_t;  // serial bit position

	typedef enum logic [2:0] {
		M_IDLE,
		M_REQUEST,
		M_START,
		M_ADDR,
		M_WDATA,
		M_RDATA,
		M_DONE
	} master_state_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_ADDR,
		S_WDATA,
		S_MEM,
		S_RDATA
	} slave_state_t;

endpackage

/* serial_bus_defs.svh */
`ifndef SERIAL_BUS_DEFS_SVH
`define SERIAL_BUS_DEFS_SVH

`define SB_ADDR_LEN 12       // address bits on the wire
`define SB_DATA_LEN 8
`define SB_SLAVE_LEN 2       // slave select width
`define SB_NUM_SLAVES 3
`define SB_SMALL_ADDR_LEN 11 // 2k slaves decode only this many

`endif
